// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_axi_interconnect
FILELIST = vlog.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_axi_interconnect.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_axi_interconnect
// golden-file testbench for the crossbar, with fetch and data
// master drivers and behavioral memory and timer slaves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_axi_interconnect;

	logic clk;
	logic rst_n;
	xbar_pkg::addr_req_t ar_fetch, ar_data, aw_data, ar_mem, aw_mem, ar_timer, aw_timer;
	xbar_pkg::rbeat_t    r_fetch, r_data, r_mem, r_timer;
	xbar_pkg::wbeat_t    w_data, w_mem, w_timer;
	xbar_pkg::bresp_t    b_data, b_mem, b_timer;
	logic ar_valid_fetch, ar_ready_fetch, r_valid_fetch, r_ready_fetch;
	logic ar_valid_data, ar_ready_data, r_valid_data, r_ready_data;
	logic aw_valid_data, aw_ready_data, w_valid_data, w_ready_data, b_valid_data, b_ready_data;
	logic ar_valid_mem, ar_ready_mem, r_valid_mem, r_ready_mem, aw_valid_mem, aw_ready_mem;
	logic w_valid_mem, w_ready_mem, b_valid_mem, b_ready_mem;
	logic ar_valid_timer, ar_ready_timer, r_valid_timer, r_ready_timer;
	logic aw_valid_timer, aw_ready_timer, w_valid_timer, w_ready_timer;
	logic b_valid_timer, b_ready_timer;

	// golden table, one entry per transaction
	int          nlines;
	int          g_grp [32];
	int          g_master [32];
	int          g_op [32];
	int          g_slave [32];
	logic [31:0] g_addr [32];
	logic [31:0] g_saddr [32];
	logic [7:0]  g_len [32];
	logic [63:0] g_wdata [32];
	logic [63:0] g_first [32];

	int   errors;
	int   checks;
	int   cycle;
	int   limit;
	int   rd_ar_cycle [2];
	int   rd_last_cycle [2];
	// read open per master, 0 fetch and 1 data
	logic rd_open [2];

	axi_interconnect u_axi_interconnect (.*);

	slave_model #(.tag(64'hA5A5_0000_0000_0000)) u_mem_slave (
		.clk(clk), .rst_n(rst_n), .ar(ar_mem), .ar_valid(ar_valid_mem), .ar_ready(ar_ready_mem),
		.r(r_mem), .r_valid(r_valid_mem), .r_ready(r_ready_mem),
		.aw(aw_mem), .aw_valid(aw_valid_mem), .aw_ready(aw_ready_mem),
		.w(w_mem), .w_valid(w_valid_mem), .w_ready(w_ready_mem),
		.b(b_mem), .b_valid(b_valid_mem), .b_ready(b_ready_mem)
	);

	slave_model #(.tag(64'h5A5A_0000_0000_0000)) u_timer_slave (
		.clk(clk), .rst_n(rst_n), .ar(ar_timer), .ar_valid(ar_valid_timer),
		.ar_ready(ar_ready_timer), .r(r_timer), .r_valid(r_valid_timer), .r_ready(r_ready_timer),
		.aw(aw_timer), .aw_valid(aw_valid_timer), .aw_ready(aw_ready_timer),
		.w(w_timer), .w_valid(w_valid_timer), .w_ready(w_ready_timer),
		.b(b_timer), .b_valid(b_valid_timer), .b_ready(b_ready_timer)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > limit) begin
			$display("timeout after %0d cycles, a transaction never completed", cycle);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// each master's rvalid stays low unless its own read is open
	always @(negedge clk) begin
		if (rst_n) begin
			assert (!r_valid_fetch || rd_open[0]) else begin
				errors++;
				$display("fetch master saw rvalid at %0t with no fetch read open", $time);
			end
			assert (!r_valid_data || rd_open[1]) else begin
				errors++;
				$display("data master saw rvalid at %0t with no data read open", $time);
			end
		end
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("error t=%0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	// slave side: right slave got the request at the rebased address
	task automatic check_slave_ar(input int n, input logic hit_mem, input logic hit_timer,
		input logic [31:0] addr_mem, input logic [31:0] addr_timer);
		check_val("ar_valid_mem seen", 64'(hit_mem), 64'(g_slave[n] == 0));
		check_val("ar_valid_timer seen", 64'(hit_timer), 64'(g_slave[n] == 1));
		check_val("slave addr", 64'(g_slave[n] ? addr_timer : addr_mem), 64'(g_saddr[n]));
	endtask

	task automatic do_read(input int n);
		xbar_pkg::addr_req_t req;
		xbar_pkg::rbeat_t    rb;
		logic                m;
		logic                got;
		int                  beat;
		m = (g_master[n] == 1);
		req = '{id: n[3:0], addr: g_addr[n], len: g_len[n]};
		@(posedge clk);
		if (m) begin
			ar_data <= req;
			ar_valid_data <= 1'b1;
		end else begin
			ar_fetch <= req;
			ar_valid_fetch <= 1'b1;
		end
		do begin
			@(posedge clk);
			got = m ? ar_ready_data : ar_ready_fetch;
		end while (!got);
		rd_ar_cycle[m] = cycle;
		if (m) ar_valid_data <= 1'b0;
		else ar_valid_fetch <= 1'b0;
		rd_open[m] = 1'b1;
		beat = 0;
		while (beat <= int'(req.len)) begin
			if (m) r_ready_data <= ($urandom_range(3) != 0);
			else r_ready_fetch <= ($urandom_range(3) != 0);
			@(posedge clk);
			if (m ? (r_valid_data && r_ready_data) : (r_valid_fetch && r_ready_fetch)) begin
				rb = m ? r_data : r_fetch;
				check_val(m ? "r_data.data" : "r_fetch.data", rb.data, g_first[n] + 64'(beat));
				check_val("r.id", 64'(rb.id), 64'(n[3:0]));
				check_val("r.last", 64'(rb.last), 64'(beat == int'(req.len)));
				beat++;
			end
		end
		rd_last_cycle[m] = cycle;
		if (m) r_ready_data <= 1'b0;
		else r_ready_fetch <= 1'b0;
		rd_open[m] = 1'b0;
		check_slave_ar(n, u_mem_slave.ar_hit[n], u_timer_slave.ar_hit[n],
			u_mem_slave.ar_addr_seen[n], u_timer_slave.ar_addr_seen[n]);
	endtask

	task automatic do_write(input int n);
		logic [31:0] seen_addr;
		logic [63:0] seen_data;
		logic [7:0]  seen_strb;
		@(posedge clk);
		aw_data <= '{id: n[3:0], addr: g_addr[n], len: g_len[n]};
		aw_valid_data <= 1'b1;
		do @(posedge clk); while (!aw_ready_data);
		aw_valid_data <= 1'b0;
		w_data <= '{data: g_wdata[n], strb: '1, last: 1'b1};
		w_valid_data <= 1'b1;
		do @(posedge clk); while (!w_ready_data);
		w_valid_data <= 1'b0;
		do begin
			b_ready_data <= ($urandom_range(3) != 0);
			@(posedge clk);
		end while (!(b_valid_data && b_ready_data));
		b_ready_data <= 1'b0;
		check_val("b_data.id", 64'(b_data.id), 64'(n[3:0]));
		check_val("aw_valid_mem seen", 64'(u_mem_slave.aw_hit[n]), 64'(g_slave[n] == 0));
		check_val("aw_valid_timer seen", 64'(u_timer_slave.aw_hit[n]), 64'(g_slave[n] == 1));
		seen_addr = g_slave[n] ? u_timer_slave.aw_addr_seen[n] : u_mem_slave.aw_addr_seen[n];
		seen_data = g_slave[n] ? u_timer_slave.w_data_seen[n] : u_mem_slave.w_data_seen[n];
		seen_strb = g_slave[n] ? u_timer_slave.w_strb_seen[n] : u_mem_slave.w_strb_seen[n];
		check_val("aw slave addr", 64'(seen_addr), 64'(g_saddr[n]));
		check_val("w slave data", seen_data, g_wdata[n]);
		// full-word writes, every byte lane enabled
		check_val("w slave strb", 64'(seen_strb), 64'(8'hff));
	endtask

	task automatic run_line(input int n);
		if (g_op[n] == 1) do_write(n);
		else do_read(n);
	endtask

	task automatic load_golden();
		int    fd;
		string line;
		nlines = 0;
		limit = 200;
		fd = $fopen("dv/xbar_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h", g_grp[nlines], g_master[nlines],
					g_op[nlines], g_addr[nlines], g_len[nlines], g_wdata[nlines],
					g_slave[nlines], g_saddr[nlines], g_first[nlines]) == 9) begin
					limit += (int'(g_len[nlines]) + 1) * 20;
					nlines++;
				end
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int i;
		int j;
		int n_fetch;
		int n_data;
		void'($urandom(32'haf97));
		{ar_fetch, ar_data, aw_data, w_data} = '0;
		{ar_valid_fetch, r_ready_fetch, ar_valid_data, r_ready_data} = '0;
		{aw_valid_data, w_valid_data, b_ready_data} = '0;
		errors = 0;
		checks = 0;
		cycle = 0;
		rd_open[0] = 1'b0;
		rd_open[1] = 1'b0;
		rst_n = 1'b0;
		load_golden();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checks++;
		assert ({ar_ready_fetch, r_valid_fetch, ar_ready_data, r_valid_data, aw_ready_data,
			w_ready_data, b_valid_data, ar_valid_mem, r_ready_mem, aw_valid_mem, w_valid_mem,
			b_ready_mem, ar_valid_timer, r_ready_timer, aw_valid_timer, w_valid_timer,
			b_ready_timer} == '0) else begin
			errors++;
			$display("a valid or ready output of the DUT was high right after reset");
		end
		i = 0;
		while (i < nlines) begin
			j = i;
			n_fetch = 0;
			n_data = 0;
			// lines sharing a group number start in the same cycle
			while (j < nlines && g_grp[j] == g_grp[i]) begin
				if (g_op[j] == 0 && g_master[j] == 0) n_fetch++;
				if (g_op[j] == 0 && g_master[j] == 1) n_data++;
				fork
					automatic int k = j;
					run_line(k);
				join_none
				j++;
			end
			wait fork;
			if (n_fetch > 0 && n_data > 0) begin
				checks++;
				assert (rd_ar_cycle[0] > rd_last_cycle[1]) else begin
					errors++;
					$display("fetch read was issued before the data read finished");
				end
			end
			i = j;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && nlines > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// one AXI slave, answers reads with address xor tag plus beat index
module slave_model #(
	parameter logic [63:0] tag = 64'h0
) (
	input  logic                clk,
	input  logic                rst_n,
	input  xbar_pkg::addr_req_t ar,
	input  logic                ar_valid,
	output logic                ar_ready,
	output xbar_pkg::rbeat_t    r,
	output logic                r_valid,
	input  logic                r_ready,
	input  xbar_pkg::addr_req_t aw,
	input  logic                aw_valid,
	output logic                aw_ready,
	input  xbar_pkg::wbeat_t    w,
	input  logic                w_valid,
	output logic                w_ready,
	output xbar_pkg::bresp_t    b,
	output logic                b_valid,
	input  logic                b_ready
);

	// what arrived here, indexed by transaction id
	logic        ar_hit [16];
	logic [31:0] ar_addr_seen [16];
	logic        aw_hit [16];
	logic [31:0] aw_addr_seen [16];
	logic [63:0] w_data_seen [16];
	logic [7:0]  w_strb_seen [16];

	initial begin
		xbar_pkg::addr_req_t req;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		for (int k = 0; k < 16; k++) begin
			ar_hit[k] = 1'b0;
			ar_addr_seen[k] = '0;
		end
		forever begin
			@(posedge clk);
			if (rst_n && ar_valid && ar_ready) begin
				req = ar;
				ar_ready <= 1'b0;
				ar_hit[req.id] = 1'b1;
				ar_addr_seen[req.id] = req.addr;
				repeat ($urandom_range(3)) @(posedge clk);
				for (int i = 0; i <= int'(req.len); i++) begin
					r <= '{id: req.id, data: ({32'h0, req.addr} ^ tag) + 64'(i), resp: '0,
						last: (i == int'(req.len))};
					r_valid <= 1'b1;
					do @(posedge clk); while (!r_ready);
				end
				r_valid <= 1'b0;
			end else begin
				ar_ready <= rst_n && ($urandom_range(3) != 0);
			end
		end
	end

	initial begin
		xbar_pkg::addr_req_t wreq;
		logic                done;
		{aw_ready, w_ready, b_valid} = '0;
		b = '0;
		for (int k = 0; k < 16; k++) begin
			aw_hit[k] = 1'b0;
			aw_addr_seen[k] = '0;
			w_data_seen[k] = '0;
			w_strb_seen[k] = '0;
		end
		forever begin
			@(posedge clk);
			if (rst_n && aw_valid && aw_ready) begin
				wreq = aw;
				aw_ready <= 1'b0;
				aw_hit[wreq.id] = 1'b1;
				aw_addr_seen[wreq.id] = wreq.addr;
				done = 1'b0;
				while (!done) begin
					w_ready <= ($urandom_range(3) != 0);
					@(posedge clk);
					if (w_valid && w_ready) begin
						w_data_seen[wreq.id] = w.data;
						w_strb_seen[wreq.id] = w.strb;
						done = w.last;
					end
				end
				w_ready <= 1'b0;
				repeat ($urandom_range(3)) @(posedge clk);
				b <= '{id: wreq.id, resp: '0};
				b_valid <= 1'b1;
				do @(posedge clk); while (!b_ready);
				b_valid <= 1'b0;
			end else begin
				aw_ready <= rst_n && ($urandom_range(3) != 0);
			end
		end
	end

endmodule

// File: dv/xbar_golden.txt
# grp master(0 fetch,1 data) op(0 read,1 write) addr len wdata
# exp_slave(0 mem,1 timer) exp_slave_addr exp_first_rdata, all hex
0 1 0 00001000 00 0000000000000000 0 00001000 a5a5000000001000
1 1 0 02000010 00 0000000000000000 1 00000010 5a5a000000000010
2 1 1 02000008 00 1122334455667788 1 00000008 0000000000000000
# same group, data read must win
3 1 0 00002000 01 0000000000000000 0 00002000 a5a5000000002000
3 0 0 00000100 00 0000000000000000 0 00000100 a5a5000000000100
4 0 0 00003000 03 0000000000000000 0 00003000 a5a5000000003000
# write alongside a fetch burst
5 0 0 00004000 03 0000000000000000 0 00004000 a5a5000000004000
5 1 1 00005000 00 cafef00d12345678 0 00005000 0000000000000000
6 0 0 02000100 01 0000000000000000 1 00000100 5a5a000000000100
7 1 1 00000040 00 0badc0de0badc0de 0 00000040 0000000000000000
8 0 0 0200fff0 00 0000000000000000 1 0000fff0 5a5a00000000fff0
9 1 0 02010000 00 0000000000000000 0 02010000 a5a5000002010000
10 1 1 02000020 00 00000000deadbeef 1 00000020 0000000000000000
10 0 0 00006000 02 0000000000000000 0 00006000 a5a5000000006000

// File: rtl/axi_interconnect.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axi_interconnect
// AXI crossbar top, fetch and data masters onto memory and
// timer slaves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module axi_interconnect (
	input  logic                clk,
	input  logic                rst_n,
	// fetch master, read only
	input  xbar_pkg::addr_req_t ar_fetch,
	input  logic                ar_valid_fetch,
	output logic                ar_ready_fetch,
	output xbar_pkg::rbeat_t    r_fetch,
	output logic                r_valid_fetch,
	input  logic                r_ready_fetch,
	// data master
	input  xbar_pkg::addr_req_t ar_data,
	input  logic                ar_valid_data,
	output logic                ar_ready_data,
	output xbar_pkg::rbeat_t    r_data,
	output logic                r_valid_data,
	input  logic                r_ready_data,
	input  xbar_pkg::addr_req_t aw_data,
	input  logic                aw_valid_data,
	output logic                aw_ready_data,
	input  xbar_pkg::wbeat_t    w_data,
	input  logic                w_valid_data,
	output logic                w_ready_data,
	output xbar_pkg::bresp_t    b_data,
	output logic                b_valid_data,
	input  logic                b_ready_data,
	// memory slave
	output xbar_pkg::addr_req_t ar_mem,
	output logic                ar_valid_mem,
	input  logic                ar_ready_mem,
	input  xbar_pkg::rbeat_t    r_mem,
	input  logic                r_valid_mem,
	output logic                r_ready_mem,
	output xbar_pkg::addr_req_t aw_mem,
	output logic                aw_valid_mem,
	input  logic                aw_ready_mem,
	output xbar_pkg::wbeat_t    w_mem,
	output logic                w_valid_mem,
	input  logic                w_ready_mem,
	input  xbar_pkg::bresp_t    b_mem,
	input  logic                b_valid_mem,
	output logic                b_ready_mem,
	// timer slave
	output xbar_pkg::addr_req_t ar_timer,
	output logic                ar_valid_timer,
	input  logic                ar_ready_timer,
	input  xbar_pkg::rbeat_t    r_timer,
	input  logic                r_valid_timer,
	output logic                r_ready_timer,
	output xbar_pkg::addr_req_t aw_timer,
	output logic                aw_valid_timer,
	input  logic                aw_ready_timer,
	output xbar_pkg::wbeat_t    w_timer,
	output logic                w_valid_timer,
	input  logic                w_ready_timer,
	input  xbar_pkg::bresp_t    b_timer,
	input  logic                b_valid_timer,
	output logic                b_ready_timer
);

	logic                  read_busy;
	xbar_pkg::master_sel_t grant_master;
	xbar_pkg::slave_sel_t  grant_target;
	logic                  ar_fire;
	logic                  r_last_fire;
	xbar_pkg::addr_req_t   ar_addr_granted;

	read_arbiter u_read_arbiter (
		.clk             (clk),
		.rst_n           (rst_n),
		.ar_valid_fetch  (ar_valid_fetch),
		.ar_valid_data   (ar_valid_data),
		.ar_fire         (ar_fire),
		.r_last_fire     (r_last_fire),
		.ar_addr_granted (ar_addr_granted),
		.read_busy       (read_busy),
		.grant_master    (grant_master),
		.grant_target    (grant_target)
	);

	// port names line up one to one with this level
	read_router u_read_router (.*);

	write_router u_write_router (.*);

endmodule

// File: rtl/read_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read_arbiter
// picks the read master (data over fetch), decodes its target
// and holds both for the life of one read burst
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module read_arbiter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ar_valid_fetch,
	input  logic                  ar_valid_data,
	input  logic                  ar_fire,
	input  logic                  r_last_fire,
	input  xbar_pkg::addr_req_t   ar_addr_granted,
	output logic                  read_busy,
	output xbar_pkg::master_sel_t grant_master,
	output xbar_pkg::slave_sel_t  grant_target
);

	xbar_pkg::master_sel_t master_q;
	xbar_pkg::slave_sel_t  target_q;
	xbar_pkg::master_sel_t req_master;
	xbar_pkg::slave_sel_t  req_target;

	// fixed priority, data port first
	always_comb begin
		if (ar_valid_data) begin
			req_master = xbar_pkg::master_data;
		end else if (ar_valid_fetch) begin
			req_master = xbar_pkg::master_fetch;
		end else begin
			// nobody asking, keep the muxes where they were
			req_master = master_q;
		end
	end

	// ar_addr_granted already follows req_master while idle
	assign req_target = xbar_pkg::decode_slave(ar_addr_granted.addr);

	// live choice while idle, latched choice while a read is open
	always_comb begin
		if (read_busy) begin
			grant_master = master_q;
			grant_target = target_q;
		end else begin
			grant_master = req_master;
			grant_target = req_target;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_busy <= 1'b0;
			master_q  <= xbar_pkg::master_fetch;
			target_q  <= xbar_pkg::slave_mem;
		end else if (ar_fire) begin
			read_busy <= 1'b1;
			master_q  <= req_master;
			target_q  <= req_target;
		end else if (r_last_fire) begin
			// burst done once its last beat is taken
			read_busy <= 1'b0;
		end
	end

endmodule

// File: rtl/read_router.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read_router
// steers the granted ar request to memory or timer and routes
// r beats back to the granted master, all combinational
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module read_router (
	input  logic                  read_busy,
	input  xbar_pkg::master_sel_t grant_master,
	input  xbar_pkg::slave_sel_t  grant_target,
	// fetch master
	input  xbar_pkg::addr_req_t   ar_fetch,
	input  logic                  ar_valid_fetch,
	output logic                  ar_ready_fetch,
	output xbar_pkg::rbeat_t      r_fetch,
	output logic                  r_valid_fetch,
	input  logic                  r_ready_fetch,
	// data master
	input  xbar_pkg::addr_req_t   ar_data,
	input  logic                  ar_valid_data,
	output logic                  ar_ready_data,
	output xbar_pkg::rbeat_t      r_data,
	output logic                  r_valid_data,
	input  logic                  r_ready_data,
	// memory slave
	output xbar_pkg::addr_req_t   ar_mem,
	output logic                  ar_valid_mem,
	input  logic                  ar_ready_mem,
	input  xbar_pkg::rbeat_t      r_mem,
	input  logic                  r_valid_mem,
	output logic                  r_ready_mem,
	// timer slave
	output xbar_pkg::addr_req_t   ar_timer,
	output logic                  ar_valid_timer,
	input  logic                  ar_ready_timer,
	input  xbar_pkg::rbeat_t      r_timer,
	input  logic                  r_valid_timer,
	output logic                  r_ready_timer,
	// handshake events for the arbiter
	output logic                  ar_fire,
	output logic                  r_last_fire,
	output xbar_pkg::addr_req_t   ar_addr_granted
);

	logic             pick_data;
	logic             pick_timer;
	logic             ar_valid_sel;
	logic             ar_ready_sel;
	xbar_pkg::rbeat_t r_sel;
	logic             r_valid_sel;
	logic             r_ready_sel;

	assign pick_data  = (grant_master == xbar_pkg::master_data);
	assign pick_timer = (grant_target == xbar_pkg::slave_timer);

	// ar path, only open while no read is in flight
	assign ar_addr_granted = pick_data ? ar_data : ar_fetch;
	assign ar_valid_sel    = !read_busy && (pick_data ? ar_valid_data : ar_valid_fetch);
	assign ar_ready_sel    = pick_timer ? ar_ready_timer : ar_ready_mem;
	assign ar_fire         = ar_valid_sel && ar_ready_sel;

	always_comb begin
		ar_mem        = ar_addr_granted;
		ar_timer      = ar_addr_granted;
		// timer sees offsets from its window base
		ar_timer.addr = ar_addr_granted.addr - xbar_pkg::timer_base;
	end

	assign ar_valid_mem   = ar_valid_sel && !pick_timer;
	assign ar_valid_timer = ar_valid_sel && pick_timer;

	// ready goes back to the chosen master only
	assign ar_ready_fetch = ar_fire && !pick_data;
	assign ar_ready_data  = ar_fire && pick_data;

	// r path from the latched slave
	assign r_sel       = pick_timer ? r_timer : r_mem;
	assign r_valid_sel = read_busy && (pick_timer ? r_valid_timer : r_valid_mem);
	assign r_ready_sel = read_busy && (pick_data ? r_ready_data : r_ready_fetch);

	assign r_fetch       = r_sel;
	assign r_data        = r_sel;
	assign r_valid_fetch = r_valid_sel && !pick_data;
	assign r_valid_data  = r_valid_sel && pick_data;

	assign r_ready_mem   = r_ready_sel && !pick_timer;
	assign r_ready_timer = r_ready_sel && pick_timer;

	// last flag only counts once the master takes the beat
	assign r_last_fire = r_valid_sel && r_ready_sel && r_sel.last;

endmodule

// File: rtl/write_router.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write_router
// routes the data master's aw, w and b channels to memory or
// timer, one write transaction open at a time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module write_router (
	input  logic                clk,
	input  logic                rst_n,
	// data master
	input  xbar_pkg::addr_req_t aw_data,
	input  logic                aw_valid_data,
	output logic                aw_ready_data,
	input  xbar_pkg::wbeat_t    w_data,
	input  logic                w_valid_data,
	output logic                w_ready_data,
	output xbar_pkg::bresp_t    b_data,
	output logic                b_valid_data,
	input  logic                b_ready_data,
	// memory slave
	output xbar_pkg::addr_req_t aw_mem,
	output logic                aw_valid_mem,
	input  logic                aw_ready_mem,
	output xbar_pkg::wbeat_t    w_mem,
	output logic                w_valid_mem,
	input  logic                w_ready_mem,
	input  xbar_pkg::bresp_t    b_mem,
	input  logic                b_valid_mem,
	output logic                b_ready_mem,
	// timer slave
	output xbar_pkg::addr_req_t aw_timer,
	output logic                aw_valid_timer,
	input  logic                aw_ready_timer,
	output xbar_pkg::wbeat_t    w_timer,
	output logic                w_valid_timer,
	input  logic                w_ready_timer,
	input  xbar_pkg::bresp_t    b_timer,
	input  logic                b_valid_timer,
	output logic                b_ready_timer
);

	logic                 write_busy;
	xbar_pkg::slave_sel_t target_q;
	xbar_pkg::slave_sel_t aw_target;
	logic                 aw_to_timer;
	logic                 aw_valid_open;
	logic                 aw_ready_sel;
	logic                 aw_fire;
	logic                 busy_timer;
	logic                 busy_mem;
	logic                 b_fire;

	assign aw_target   = xbar_pkg::decode_slave(aw_data.addr);
	assign aw_to_timer = (aw_target == xbar_pkg::slave_timer);

	// aw path, idle only
	assign aw_valid_open = !write_busy && aw_valid_data;
	assign aw_ready_sel  = aw_to_timer ? aw_ready_timer : aw_ready_mem;
	assign aw_fire       = aw_valid_open && aw_ready_sel;
	assign aw_ready_data = aw_fire;

	always_comb begin
		aw_mem        = aw_data;
		aw_timer      = aw_data;
		aw_timer.addr = aw_data.addr - xbar_pkg::timer_base;
	end

	assign aw_valid_mem   = aw_valid_open && !aw_to_timer;
	assign aw_valid_timer = aw_valid_open && aw_to_timer;

	// w and b follow the slave latched at the aw handshake
	assign busy_timer = write_busy && (target_q == xbar_pkg::slave_timer);
	assign busy_mem   = write_busy && (target_q == xbar_pkg::slave_mem);

	assign w_mem         = w_data;
	assign w_timer       = w_data;
	assign w_valid_mem   = busy_mem && w_valid_data;
	assign w_valid_timer = busy_timer && w_valid_data;
	assign w_ready_data  = (busy_mem && w_ready_mem) || (busy_timer && w_ready_timer);

	// response keeps the slave's id, which is the master's original id
	assign b_data        = busy_timer ? b_timer : b_mem;
	assign b_valid_data  = (busy_mem && b_valid_mem) || (busy_timer && b_valid_timer);
	assign b_ready_mem   = busy_mem && b_ready_data;
	assign b_ready_timer = busy_timer && b_ready_data;

	assign b_fire = b_valid_data && b_ready_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			write_busy <= 1'b0;
			target_q   <= xbar_pkg::slave_mem;
		end else if (aw_fire) begin
			write_busy <= 1'b1;
			target_q   <= aw_target;
		end else if (b_fire) begin
			// free for the next aw
			write_busy <= 1'b0;
		end
	end

endmodule

// File: rtl/xbar_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// xbar_pkg
// shared widths, timer window, AXI channel payloads and the
// address decode for the two-master, two-slave crossbar
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package xbar_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int strb_w = data_w / 8;
	localparam int id_w   = 4;
	// beats minus one
	localparam int len_w  = 8;
	localparam int resp_w = 2;

	// timer window, inclusive on both ends
	localparam logic [addr_w-1:0] timer_base = 32'h0200_0000;
	localparam logic [addr_w-1:0] timer_last = 32'h0200_FFFF;

	typedef enum logic {
		slave_mem   = 1'b0,
		slave_timer = 1'b1
	} slave_sel_t;

	typedef enum logic {
		master_fetch = 1'b0,
		master_data  = 1'b1
	} master_sel_t;

	// shared by ar and aw
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [addr_w-1:0] addr;
		logic [len_w-1:0]  len;
	} addr_req_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} wbeat_t;

	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [data_w-1:0] data;
		logic [resp_w-1:0] resp;
		logic              last;
	} rbeat_t;

	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [resp_w-1:0] resp;
	} bresp_t;

	// anything outside the timer window lands in memory
	function automatic slave_sel_t decode_slave(input logic [addr_w-1:0] addr);
		return ((addr >= timer_base) && (addr <= timer_last)) ? slave_timer : slave_mem;
	endfunction

endpackage

// File: vlog.f
rtl/xbar_pkg.sv
rtl/read_arbiter.sv
rtl/read_router.sv
rtl/write_router.sv
rtl/axi_interconnect.sv
dv/tb_axi_interconnect.sv
